// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = tb_icache
FILELIST = verilog.f

OBJ_DIR  = obj_dir
SIM_BIN  = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/icache_geom_pkg.sv
`default_nettype none

// geometry of the direct mapped icache, one word per line
package icache_geom_pkg;

    // fetch address split  | tag | index | offset |
    localparam int FETCH_ADDR_W = 14;  // byte address from the core
    localparam int OFFSET_W     = 2;   // byte within the 32-bit word
    localparam int INDEX_W      = 6;   // set select, also array addr width
    localparam int TAG_W        = 6;   // what is left above the index

    // array sizes
    localparam int NUM_SETS     = 64;  // 2**INDEX_W, swept after reset
    localparam int WORD_W       = 32;  // data array and fetch/refill width

    // field positions inside a fetch address
    localparam int INDEX_LSB    = OFFSET_W;
    localparam int TAG_LSB      = OFFSET_W + INDEX_W;

endpackage

`default_nettype wire

// File: hw/icache_hit_stage.sv
`timescale 1ns/100ps
`default_nettype none

// stage 2: tag compare, hit data or miss flag, refill forwarding
module icache_hit_stage
    import icache_geom_pkg::*;
    import icache_tag_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    s1_valid,
    input  logic [TAG_W-1:0]        s1_tag,
    input  logic [FETCH_ADDR_W-1:0] s1_addr,
    input  logic [TAG_ENTRY_W-1:0]  tag_rdata,   // raw word from the tag array
    input  logic [WORD_W-1:0]       data_rdata,
    input  logic                    refill_done, // refill word is on refill_word
    input  logic [WORD_W-1:0]       refill_word,
    output logic                    fetch_valid,
    output logic [WORD_W-1:0]       fetch_rdata,
    output logic                    miss,        // also kills stage 1
    output logic [FETCH_ADDR_W-1:0] miss_addr
);

    tag_entry_u entry;
    logic       hit;

    // the array gives raw bits, compare through the field view
    assign entry.raw = tag_rdata;
    assign hit       = s1_valid & entry.fld.valid & (entry.fld.tag == s1_tag);

    // one cycle only, stage 1 drops s1_valid right after
    assign miss      = s1_valid & ~hit;
    assign miss_addr = s1_addr;

    // response valid
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            fetch_valid <= 1'b0;
        end
        else
        begin
            fetch_valid <= hit | refill_done;  // never both, s1 is empty during refill
        end
    end

    // response word
    always_ff @(posedge clk)
    begin
        if (refill_done)
        begin
            fetch_rdata <= refill_word;  // straight from memory
        end
        else if (hit)
        begin
            fetch_rdata <= data_rdata;
        end
    end

endmodule

`default_nettype wire

// File: hw/icache_lookup_stage.sv
`timescale 1ns/100ps
`default_nettype none

// stage 1: take the fetch, start the array read, keep one entry for replay
module icache_lookup_stage
    import icache_geom_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    fetch_req,
    input  logic [FETCH_ADDR_W-1:0] fetch_addr,
    input  logic                    fetch_ready,
    input  logic                    kill,    // miss in stage 2 this cycle
    input  logic                    replay,  // reissue the held entry
    output logic                    rd_req,
    output logic [INDEX_W-1:0]      rd_index,
    output logic                    s1_valid,
    output logic [TAG_W-1:0]        s1_tag,
    output logic [FETCH_ADDR_W-1:0] s1_addr
);

    logic accept;  // fetch taken at the coming edge
    logic reissue; // held entry goes out again
    logic held;    // s1_addr/s1_tag belong to a parked fetch

    assign accept  = fetch_req & fetch_ready;
    assign reissue = replay & held;  // ready is low then, no accept in parallel

    // array read, new fetch or the parked one
    assign rd_req   = accept | reissue;
    assign rd_index = accept ? fetch_addr[INDEX_LSB +: INDEX_W]
                             : s1_addr[INDEX_LSB +: INDEX_W];

    // control
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            s1_valid <= 1'b0;
            held     <= 1'b0;
        end
        else
        begin
            // a fetch arriving with kill never reaches stage 2 now
            s1_valid <= (accept & ~kill) | reissue;
            if (accept & kill)
            begin
                held <= 1'b1;  // parked until the refill is done
            end
            else if (reissue)
            begin
                held <= 1'b0;
            end
        end
    end

    // request payload, kept as is while parked
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            s1_addr <= fetch_addr;
            s1_tag  <= fetch_addr[TAG_LSB +: TAG_W];
        end
    end

endmodule

`default_nettype wire

// File: hw/icache_refill_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

// reset sweep, miss refill and array writes; owns fetch_ready
//   sweep  -> idle -> wait -> finish -> idle
//   idle is the phase with fetch_ready high
module icache_refill_ctrl
    import icache_geom_pkg::*;
    import icache_tag_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    miss,
    input  logic [FETCH_ADDR_W-1:0] miss_addr,
    input  logic                    refill_valid,  // memory answer pulse
    input  logic [WORD_W-1:0]       refill_rdata,
    output logic                    refill_req,    // one cycle
    output logic [FETCH_ADDR_W-1:0] refill_addr,   // held until refill_valid
    output logic                    wr_req,
    output logic [INDEX_W-1:0]      wr_index,
    output logic [TAG_ENTRY_W-1:0]  wr_tag,
    output logic [WORD_W-1:0]       wr_data,
    output logic                    refill_done,
    output logic                    replay,
    output logic                    fetch_ready
);

    logic               sweep_on;   // reset sweep running
    logic [INDEX_W-1:0] sweep_cnt;  // set being cleared
    logic               sweep_last;
    logic               wait_on;    // refill_req sent, waiting for memory
    logic               finish_on;  // arrays written, replay slot
    logic               fill;       // refill write this cycle
    logic [INDEX_W-1:0] fill_index;
    logic [TAG_W-1:0]   fill_tag;
    tag_entry_u         wr_entry;

    assign sweep_last = (sweep_cnt == INDEX_W'(NUM_SETS - 1));
    assign fill       = wait_on & refill_valid;

    // line being refilled, from the latched miss address
    assign fill_index = refill_addr[INDEX_LSB +: INDEX_W];
    assign fill_tag   = refill_addr[TAG_LSB +: TAG_W];

    // array write, the sweep or the refill, never both
    assign wr_req   = sweep_on | fill;
    assign wr_index = sweep_on ? sweep_cnt : fill_index;
    assign wr_data  = refill_rdata;  // don't care during the sweep

    always_comb
    begin
        wr_entry.fld.valid = ~sweep_on;                  // sweep writes invalid
        wr_entry.fld.tag   = sweep_on ? '0 : fill_tag;
    end
    assign wr_tag = wr_entry.raw;

    assign refill_done = fill;       // hit stage registers the word at this edge
    assign replay      = finish_on;  // arrays already hold the new line

    // phase control
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sweep_on    <= 1'b1;  // start clearing right away
            sweep_cnt   <= '0;
            wait_on     <= 1'b0;
            finish_on   <= 1'b0;
            fetch_ready <= 1'b0;
            refill_req  <= 1'b0;
        end
        else
        begin
            refill_req <= 1'b0;  // pulse by default
            finish_on  <= 1'b0;
            if (sweep_on)
            begin
                sweep_cnt <= sweep_cnt + 1'b1;
                if (sweep_last)
                begin
                    sweep_on    <= 1'b0;
                    fetch_ready <= 1'b1;  // open the cycle after the last write
                end
            end
            else if (fetch_ready)
            begin
                if (miss)
                begin
                    fetch_ready <= 1'b0;
                    wait_on     <= 1'b1;
                    refill_req  <= 1'b1;
                end
            end
            else if (wait_on)
            begin
                if (refill_valid)
                begin
                    wait_on   <= 1'b0;
                    finish_on <= 1'b1;
                end
            end
            else if (finish_on)
            begin
                fetch_ready <= 1'b1;  // replay result arrives with the open port
            end
        end
    end

    // word aligned miss address, kept for the whole wait
    always_ff @(posedge clk)
    begin
        if (fetch_ready & miss)
        begin
            refill_addr <= {miss_addr[FETCH_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        end
    end

endmodule

`default_nettype wire

// File: hw/icache_tag_pkg.sv
`default_nettype none

// format of one tag array entry
package icache_tag_pkg;

    import icache_geom_pkg::*;

    localparam int TAG_ENTRY_W = TAG_W + 1;  // valid bit on top of the tag

    // compare-side view
    typedef struct packed {
        logic             valid;  // msb, cleared by the reset sweep
        logic [TAG_W-1:0] tag;
    } tag_fields_t;

    // the array only ever sees raw, the hit check and refill use fld
    typedef union packed {
        logic [TAG_ENTRY_W-1:0] raw;
        tag_fields_t            fld;
    } tag_entry_u;

endpackage

`default_nettype wire

// File: hw/icache_top.sv
`timescale 1ns/100ps
`default_nettype none

// icache lookup subsystem, two stage fetch pipe plus refill controller
module icache_top
    import icache_geom_pkg::*;
    import icache_tag_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    // fetch side
    input  logic                    fetch_req,
    input  logic [FETCH_ADDR_W-1:0] fetch_addr,
    output logic                    fetch_ready,
    output logic                    fetch_valid,
    output logic [WORD_W-1:0]       fetch_rdata,

    // memory side
    output logic                    refill_req,
    output logic [FETCH_ADDR_W-1:0] refill_addr,
    input  logic                    refill_valid,
    input  logic [WORD_W-1:0]       refill_rdata
);

    // stage 1 -> arrays, stage 2
    logic                    rd_req;
    logic [INDEX_W-1:0]      rd_index;
    logic                    s1_valid;
    logic [TAG_W-1:0]        s1_tag;
    logic [FETCH_ADDR_W-1:0] s1_addr;

    // controller -> arrays
    logic                    wr_req;
    logic [INDEX_W-1:0]      wr_index;
    logic [TAG_ENTRY_W-1:0]  wr_tag;
    logic [WORD_W-1:0]       wr_data;

    // arrays -> stage 2
    logic [TAG_ENTRY_W-1:0]  tag_rdata;
    logic [WORD_W-1:0]       data_rdata;

    // stage 2 <-> controller
    logic                    miss;
    logic [FETCH_ADDR_W-1:0] miss_addr;
    logic                    refill_done;
    logic                    replay;

    // tag port mux, write wins (only while fetch_ready is low anyway)
    logic [INDEX_W-1:0]      tag_addr;
    logic                    tag_req;
    logic                    data_rd_en;

    assign tag_addr   = wr_req ? wr_index : rd_index;
    assign tag_req    = rd_req | wr_req;
    assign data_rd_en = rd_req & ~wr_req;

    icache_lookup_stage u_lookup
    (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .fetch_req   ( fetch_req   ),
        .fetch_addr  ( fetch_addr  ),
        .fetch_ready ( fetch_ready ),
        .kill        ( miss        ),  // the miss strobe doubles as kill
        .replay      ( replay      ),
        .rd_req      ( rd_req      ),
        .rd_index    ( rd_index    ),
        .s1_valid    ( s1_valid    ),
        .s1_tag      ( s1_tag      ),
        .s1_addr     ( s1_addr     )
    );

    ram_ws_rs_tag_scm
    #(
        .data_width ( TAG_ENTRY_W ),
        .addr_width ( INDEX_W     )
    )
    u_tag_ram
    (
        .clk   ( clk       ),
        .rst_n ( rst_n     ),
        .addr  ( tag_addr  ),
        .req   ( tag_req   ),
        .write ( wr_req    ),
        .wdata ( wr_tag    ),
        .rdata ( tag_rdata )
    );

    // data array has separate ports, no wrapper needed
    register_file_1r_1w
    #(
        .data_width ( WORD_W  ),
        .addr_width ( INDEX_W )
    )
    u_data_ram
    (
        .clk          ( clk        ),
        .rst_n        ( rst_n      ),
        .read_enable  ( data_rd_en ),
        .read_addr    ( rd_index   ),
        .read_data    ( data_rdata ),
        .write_enable ( wr_req     ),
        .write_addr   ( wr_index   ),
        .write_data   ( wr_data    )
    );

    icache_hit_stage u_hit
    (
        .clk         ( clk          ),
        .rst_n       ( rst_n        ),
        .s1_valid    ( s1_valid     ),
        .s1_tag      ( s1_tag       ),
        .s1_addr     ( s1_addr      ),
        .tag_rdata   ( tag_rdata    ),
        .data_rdata  ( data_rdata   ),
        .refill_done ( refill_done  ),
        .refill_word ( refill_rdata ),
        .fetch_valid ( fetch_valid  ),
        .fetch_rdata ( fetch_rdata  ),
        .miss        ( miss         ),
        .miss_addr   ( miss_addr    )
    );

    icache_refill_ctrl u_refill
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .miss         ( miss         ),
        .miss_addr    ( miss_addr    ),
        .refill_valid ( refill_valid ),
        .refill_rdata ( refill_rdata ),
        .refill_req   ( refill_req   ),
        .refill_addr  ( refill_addr  ),
        .wr_req       ( wr_req       ),
        .wr_index     ( wr_index     ),
        .wr_tag       ( wr_tag       ),
        .wr_data      ( wr_data      ),
        .refill_done  ( refill_done  ),
        .replay       ( replay       ),
        .fetch_ready  ( fetch_ready  )
    );

endmodule

`default_nettype wire

// File: hw/ram_ws_rs_tag_scm.sv
`timescale 1ns/100ps
`default_nettype none

// single port tag array on top of the flop register file
module ram_ws_rs_tag_scm
#(
    parameter int data_width = 7,
    parameter int addr_width = 6
)
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [addr_width-1:0] addr,
    input  logic                  req,    // access this cycle
    input  logic                  write,  // 1 = write, 0 = read
    input  logic [data_width-1:0] wdata,
    output logic [data_width-1:0] rdata
);

    logic rd_en;
    logic wr_en;

    // split req/write into the two port enables
    assign rd_en = req & ~write;
    assign wr_en = req & write;

    register_file_1r_1w
    #(
        .data_width ( data_width ),
        .addr_width ( addr_width )
    )
    scm_tag
    (
        .clk          ( clk   ),
        .rst_n        ( rst_n ),
        .read_enable  ( rd_en ),
        .read_addr    ( addr  ),
        .read_data    ( rdata ),
        .write_enable ( wr_en ),
        .write_addr   ( addr  ),  // same addr for both, single port
        .write_data   ( wdata )
    );

endmodule

`default_nettype wire

// File: hw/register_file_1r_1w.sv
`timescale 1ns/100ps
`default_nettype none

// flop array, one registered read port and one write port
module register_file_1r_1w
#(
    parameter int data_width = 32,
    parameter int addr_width = 6
)
(
    input  logic                  clk,
    input  logic                  rst_n,

    // read port, data shows up the cycle after read_enable
    input  logic                  read_enable,
    input  logic [addr_width-1:0] read_addr,
    output logic [data_width-1:0] read_data,

    // write port
    input  logic                  write_enable,
    input  logic [addr_width-1:0] write_addr,
    input  logic [data_width-1:0] write_data
);

    localparam int NUM_WORDS = 2**addr_width;

    logic [data_width-1:0] mem [NUM_WORDS];  // storage, contents start undefined

    // write side
    always_ff @(posedge clk)
    begin
        if (write_enable)
        begin
            mem[write_addr] <= write_data;
        end
    end

    // registered read, holds its value when not enabled
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            read_data <= '0;
        end
        else if (read_enable)
        begin
            read_data <= mem[read_addr];  // old data if same addr is written now
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_icache.sv
`timescale 1ns/100ps
`default_nettype none

// icache_top testbench, memory model plus reference cache model, in order compare
module tb_icache
    import icache_geom_pkg::*;
();

    localparam int MAX_CYCLES = 4000;  // ~316 fetches, worst refill about 14 cycles

    logic                    clk;
    logic                    rst_n;
    logic                    fetch_req;
    logic [FETCH_ADDR_W-1:0] fetch_addr;
    logic                    fetch_ready;
    logic                    fetch_valid;
    logic [WORD_W-1:0]       fetch_rdata;
    logic                    refill_req;
    logic [FETCH_ADDR_W-1:0] refill_addr;
    logic                    refill_valid;
    logic [WORD_W-1:0]       refill_rdata;

    integer seed = 32'hd438;
    int     cycle_cnt = 0;
    string  test_name = "reset";
    int     test_errors, test_fetches, test_misses, test_refills;
    int     total_errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;

    logic [WORD_W-1:0]       exp_word_q [$];  // expected responses, fetch order
    logic [FETCH_ADDR_W-1:0] exp_miss_q [$];  // expected refill addresses

    // reference cache state
    logic             ref_valid [NUM_SETS];
    logic [TAG_W-1:0] ref_tag   [NUM_SETS];

    icache_top icache_top_inst
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .fetch_req    ( fetch_req    ),
        .fetch_addr   ( fetch_addr   ),
        .fetch_ready  ( fetch_ready  ),
        .fetch_valid  ( fetch_valid  ),
        .fetch_rdata  ( fetch_rdata  ),
        .refill_req   ( refill_req   ),
        .refill_addr  ( refill_addr  ),
        .refill_valid ( refill_valid ),
        .refill_rdata ( refill_rdata )
    );

    // memory contents, a fixed scramble of the word address
    function automatic logic [WORD_W-1:0] scramble_word(input logic [FETCH_ADDR_W-1:0] addr);
        logic [WORD_W-1:0] wa;
        wa = {{(WORD_W - FETCH_ADDR_W + OFFSET_W){1'b0}}, addr[FETCH_ADDR_W-1:OFFSET_W]};
        return (wa * 32'h9e37_79b1) ^ 32'h3c5a_0f96;
    endfunction

    // direct mapped model, updates the tag state in fetch order
    function automatic logic [WORD_W-1:0] ref_fetch(input logic [FETCH_ADDR_W-1:0] addr,
                                                    output bit miss);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tg;
        idx  = addr[OFFSET_W +: INDEX_W];
        tg   = addr[OFFSET_W + INDEX_W +: TAG_W];
        miss = !(ref_valid[idx] && ref_tag[idx] == tg);
        ref_valid[idx] = 1'b1;  // a miss always fills
        ref_tag[idx]   = tg;
        return scramble_word(addr);
    endfunction

    function automatic logic [FETCH_ADDR_W-1:0] make_addr(input int tg, input int ix, input int of);
        return {tg[TAG_W-1:0], ix[INDEX_W-1:0], of[OFFSET_W-1:0]};
    endfunction

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // run limit
    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES)
        begin
            $display("timeout after %0d cycles, the DUT stopped answering", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // memory, answers each refill_req 2 to 9 cycles later
    initial
    begin
        logic [31:0] rnd;
        int          delay;
        refill_valid = 1'b0;
        refill_rdata = '0;
        forever
        begin
            @(negedge clk);
            if (rst_n && refill_req)
            begin
                rnd   = $random(seed);
                delay = 2 + int'(rnd[2:0]);
                repeat (delay) @(posedge clk);
                #1;
                refill_valid = 1'b1;
                refill_rdata = scramble_word(refill_addr);  // addr held until now
                @(posedge clk);
                #1;
                refill_valid = 1'b0;
            end
        end
    end

    // compare, mid cycle where outputs are settled
    always @(negedge clk)
    begin
        logic [WORD_W-1:0]       exp_word;
        logic [FETCH_ADDR_W-1:0] exp_addr;
        if (rst_n && fetch_valid)
        begin
            if (exp_word_q.size() == 0)
            begin
                $display("%s: fetch_valid pulsed with no fetch outstanding", test_name);
                test_errors++;
                total_errors++;
            end
            else
            begin
                exp_word = exp_word_q.pop_front();
                if (fetch_rdata !== exp_word)
                begin
                    $display("[FAIL] %s fetch_rdata: expected %h actual %h",
                             test_name, exp_word, fetch_rdata);
                    test_errors++;
                    total_errors++;
                end
            end
        end
        if (rst_n && refill_req)
        begin
            test_refills++;
            if (exp_miss_q.size() == 0)
            begin
                $display("%s: refill_req pulsed although no miss was expected", test_name);
                test_errors++;
                total_errors++;
            end
            else
            begin
                exp_addr = exp_miss_q.pop_front();
                if (refill_addr !== exp_addr)
                begin
                    $display("[FAIL] %s refill_addr: expected %h actual %h",
                             test_name, exp_addr, refill_addr);
                    test_errors++;
                    total_errors++;
                end
            end
        end
    end

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual)
        begin
            $display("[FAIL] %s %s: expected %0d actual %0d", test_name, what, expected, actual);
            test_errors++;
            total_errors++;
        end
    endtask

    // one accepted fetch, caller sits 1 ns after a rising edge
    task automatic issue_fetch(input logic [FETCH_ADDR_W-1:0] addr);
        logic [WORD_W-1:0] word;
        bit                miss;
        while (!fetch_ready)
        begin
            @(posedge clk);
            #1;
        end
        fetch_req  = 1'b1;
        fetch_addr = addr;
        word = ref_fetch(addr, miss);
        exp_word_q.push_back(word);
        test_fetches++;
        if (miss)
        begin
            exp_miss_q.push_back({addr[FETCH_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
            test_misses++;
        end
        @(posedge clk);
        #1;
        fetch_req = 1'b0;
    endtask

    // all responses back and the port open again
    task automatic drain();
        while (exp_word_q.size() != 0 || !fetch_ready || refill_valid)
        begin
            @(posedge clk);
            #1;
        end
        repeat (2)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        test_errors  = 0;
        test_fetches = 0;
        test_misses  = 0;
        test_refills = 0;
    endtask

    task automatic end_test();
        drain();
        check_value("refill count", test_misses, test_refills);
        $display("test %-16s fetches %0d  misses %0d  refills %0d  errors %0d",
                 test_name, test_fetches, test_misses, test_refills, test_errors);
        tests_run++;
        if (test_errors != 0)
        begin
            tests_failed++;
        end
    endtask

    initial
    begin
        logic [31:0] rnd;
        int          ready_wait;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        rst_n      = 1'b0;
        for (int i = 0; i < NUM_SETS; i++)
        begin
            ref_valid[i] = 1'b0;  // sweep leaves every set invalid
            ref_tag[i]   = '0;
        end
        start_test("reset_fill");
        repeat (3) @(posedge clk);
        #1;
        // unknown bits count as wrong here
        if ({fetch_valid, refill_req, fetch_ready} !== 3'b000)
        begin
            $display("[FAIL] %s outputs in reset: expected 000 actual %b",
                     test_name, {fetch_valid, refill_req, fetch_ready});
            test_errors++;
            total_errors++;
        end
        rst_n = 1'b1;

        // 1: sweep length, then first touch of every set misses
        ready_wait = 0;
        while (!fetch_ready)
        begin
            @(posedge clk);
            #1;
            ready_wait++;
        end
        check_value("cycles to fetch_ready", NUM_SETS, ready_wait);
        for (int k = 0; k < NUM_SETS; k++)
        begin
            issue_fetch(make_addr(1, k, k % 4));
        end
        drain();
        check_value("refills", NUM_SETS, test_refills);
        end_test();

        // 2: back to back hits
        start_test("hit_stream");
        for (int k = 0; k < 32; k++)
        begin
            issue_fetch(make_addr(1, k, 3 - k % 4));
        end
        drain();
        check_value("refills", 0, test_refills);
        end_test();

        // 3: same index, other tag, then the old line again
        start_test("replace");
        issue_fetch(make_addr(2, 5, 0));
        drain();
        issue_fetch(make_addr(1, 5, 2));  // evicted, misses again
        drain();
        issue_fetch(make_addr(2, 5, 1));
        issue_fetch(make_addr(2, 5, 1));
        drain();
        check_value("refills", 3, test_refills);
        end_test();

        // 4: miss with a younger fetch right behind it
        start_test("miss_then_fetch");
        for (int k = 0; k < 8; k++)
        begin
            issue_fetch(make_addr(3, 8 + k, 0));
            case (k % 4)
                0: issue_fetch(make_addr(3, 8 + k, 2));   // same line
                1: issue_fetch(make_addr(1, 20 + k, 1));  // other set, hit
                2: issue_fetch(make_addr(3, 40 + k, 0));  // other set, miss
                default: issue_fetch(make_addr(1, 8 + k, 0));  // evicts the older
            endcase
            drain();
        end
        end_test();

        // 5: random stream over 8 sets and 2 tags
        start_test("random_stream");
        for (int k = 0; k < 200; k++)
        begin
            rnd = $random(seed);
            issue_fetch(make_addr(int'(rnd[0]), int'(rnd[3:1]), int'(rnd[5:4])));
            if (rnd[8])
            begin
                @(posedge clk);  // idle gap now and then
                #1;
            end
        end
        end_test();

        $display("tests %0d  failed %0d  errors %0d  cycles %0d",
                 tests_run, tests_failed, total_errors, cycle_cnt);
        if (total_errors == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hw/icache_geom_pkg.sv
hw/icache_tag_pkg.sv
hw/register_file_1r_1w.sv
hw/ram_ws_rs_tag_scm.sv
hw/icache_lookup_stage.sv
hw/icache_hit_stage.sv
hw/icache_refill_ctrl.sv
hw/icache_top.sv
sim/tb_icache.sv
